//--- Bender.yml
package:
  name: pkt_switch

sources:
  - switch_pkg.sv
  - ingress_ctrl.sv
  - page_free_list.sv
  - packet_buffer.sv
  - queue_table.sv
  - egress_sched.sv
  - pkt_switch_top.sv
  - target: simulation
    files:
      - tb_pkt_switch.sv

//--- egress_sched.sv
`timescale 1ns/10ps

module egress_sched import switch_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_PORTS-1:0]             ready,
    input  logic [NUM_QUEUES-1:0]            nonempty,
    input  page_t                            head_page,
    input  logic [WORD_W-1:0]                rd_word,
    input  page_t                            rd_link,
    output logic                             deq,
    output logic [PORT_W-1:0]                deq_port,
    output logic [PRIO_W-1:0]                deq_prio,
    output buf_rd_t                          buf_rd,
    output logic                             release_en,
    output page_t                            release_page,
    output logic [NUM_PORTS-1:0]             rd_sop,
    output logic [NUM_PORTS-1:0]             rd_eop,
    output logic [NUM_PORTS-1:0]             rd_vld,
    output logic [NUM_PORTS-1:0][WORD_W-1:0] rd_data
);

    logic [1:0]           state;
    logic [PORT_W-1:0]    gnt_port;
    logic [PORT_W-1:0]    rr_ptr;
    page_t                cur_page;
    logic [OFFS_W-1:0]    rd_offs;
    logic [LEN_W-1:0]     rd_cnt;
    logic [LEN_W-1:0]     len_q;
    // data of last cycle's read shows up now
    logic                 rd_pend;
    logic                 pend_sop;
    logic                 pend_eop;

    logic [NUM_PORTS-1:0] elig;
    logic                 any_elig;
    logic [PORT_W-1:0]    pick;
    logic [NUM_PRIO-1:0]  port_ne;
    pkt_word_u            out_word;
    logic [LEN_W-1:0]     len_cur;
    logic                 issue;
    logic                 last_issue;

    // ready and something queued
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            elig[p] = ready[p] && (nonempty[p * NUM_PRIO +: NUM_PRIO] != '0);
        end
    end

    // first eligible port at or after the pointer
    always_comb begin
        logic [PORT_W-1:0] idx;
        any_elig = 1'b0;
        pick = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = rr_ptr + PORT_W'(i);
            if (!any_elig && elig[idx]) begin
                any_elig = 1'b1;
                pick = idx;
            end
        end
    end

    // strict priority, highest set bit wins
    assign port_ne = nonempty[{gnt_port, {PRIO_W{1'b0}}} +: NUM_PRIO];
    always_comb begin
        deq_prio = '0;
        for (int pr = 0; pr < NUM_PRIO; pr++) begin
            if (port_ne[pr]) begin
                deq_prio = PRIO_W'(pr);
            end
        end
    end

    assign deq = (state == EG_GRANT);
    assign deq_port = gnt_port;

    // header arrives in the first stream cycle
    assign out_word = rd_word;
    assign len_cur = pend_sop ? out_word.hdr.len : len_q;
    assign issue = (state == EG_STREAM) && (rd_cnt < len_cur);
    assign last_issue = (rd_cnt == len_cur - 1'b1);

    always_comb begin
        buf_rd.en = issue || (state == EG_GRANT);
        buf_rd.page = cur_page;
        buf_rd.offs = rd_offs;
        if (state == EG_GRANT) begin
            buf_rd.page = head_page;
            buf_rd.offs = '0;
        end else if (rd_offs == '0) begin
            // link of the page just finished is on rd_link now
            buf_rd.page = rd_link;
        end
    end

    // free a page with its last needed read
    // header-only packet frees its page in the first stream cycle
    assign release_en = (issue && ((rd_offs == OFFS_W'(PAGE_WORDS - 1)) || last_issue))
                     || (pend_sop && !issue);
    assign release_page = buf_rd.page;

    // only the granted port sees strobes and data
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_vld[p] = rd_pend && (gnt_port == PORT_W'(p));
            rd_sop[p] = rd_vld[p] && pend_sop;
            rd_eop[p] = rd_vld[p] && (pend_eop || (pend_sop && (len_cur <= LEN_W'(1))));
            rd_data[p] = rd_vld[p] ? rd_word : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EG_IDLE;
            gnt_port <= '0;
            rr_ptr <= '0;
            rd_pend <= 1'b0;
            pend_sop <= 1'b0;
            pend_eop <= 1'b0;
        end else begin
            rd_pend <= buf_rd.en;
            pend_sop <= (state == EG_GRANT);
            pend_eop <= issue && last_issue;
            case (state)
                EG_IDLE: begin
                    // ready only counts here
                    if (any_elig) begin
                        gnt_port <= pick;
                        state <= EG_GRANT;
                    end
                end
                EG_GRANT: begin
                    rr_ptr <= gnt_port + 1'b1;
                    state <= EG_STREAM;
                end
                EG_STREAM: begin
                    // last word still in flight, drains while idle
                    if (!issue) begin
                        state <= EG_IDLE;
                    end
                end
                default: state <= EG_IDLE;
            endcase
        end
    end

    // read position, header read counts as the first
    always_ff @(posedge clk) begin
        if (state == EG_GRANT) begin
            cur_page <= head_page;
            rd_offs <= OFFS_W'(1);
            rd_cnt <= LEN_W'(1);
        end else if (issue) begin
            cur_page <= buf_rd.page;
            rd_offs <= rd_offs + 1'b1;
            rd_cnt <= rd_cnt + 1'b1;
        end
        if (pend_sop) begin
            len_q <= out_word.hdr.len;
        end
    end

endmodule

//--- ingress_ctrl.sv
`timescale 1ns/10ps

module ingress_ctrl import switch_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  logic [WORD_W-1:0] wr_data,
    input  page_t             alloc_page,
    output logic              alloc,
    output buf_wr_t           buf_wr,
    output logic              enq,
    output pkt_desc_t         enq_desc
);

    logic              state;
    page_t             cur_page;
    logic [OFFS_W-1:0] offs;
    pkt_desc_t         desc_q;

    pkt_word_u         in_word;
    logic              first;
    logic              take;
    logic              new_page;
    pkt_desc_t         cur_desc;

    // header view of the incoming word
    assign in_word = wr_data;

    // sop opens a packet, stray words while idle are dropped
    assign first = (state == ING_IDLE) && wr_vld && wr_sop;
    assign take = first || ((state == ING_PKT) && wr_vld);

    // offset wrapped back to zero, current page is full
    assign new_page = first || (offs == '0);
    assign alloc = take && new_page;

    // routing fields come straight off the header on the first word
    assign cur_desc = first ? pkt_desc_t'{dest: in_word.hdr.dest, prio: in_word.hdr.prio,
                                          head: alloc_page} : desc_q;

    always_comb begin
        buf_wr.word_we = take;
        buf_wr.word_page = new_page ? alloc_page : cur_page;
        buf_wr.word_offs = first ? '0 : offs;
        buf_wr.data = wr_data;
        // old page points at the new one, nothing to link on the head page
        buf_wr.link_we = alloc && !first;
        buf_wr.link_page = cur_page;
        buf_wr.next_page = alloc_page;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ING_IDLE;
            enq <= 1'b0;
        end else begin
            // enqueue one cycle after eop is written
            enq <= take && wr_eop;
            if (take) begin
                state <= wr_eop ? ING_IDLE : ING_PKT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            offs <= buf_wr.word_offs + 1'b1;
            desc_q <= cur_desc;
            if (new_page) begin
                cur_page <= alloc_page;
            end
            if (wr_eop) begin
                enq_desc <= cur_desc;
            end
        end
    end

endmodule

//--- packet_buffer.sv
`timescale 1ns/10ps

module packet_buffer import switch_pkg::*; (
    input  logic              clk,
    input  buf_wr_t           buf_wr,
    input  buf_rd_t           buf_rd,
    output logic [WORD_W-1:0] rd_word,
    output page_t             rd_link
);

    // word address is page number above word offset
    logic [WORD_W-1:0] word_mem [NUM_PAGES * PAGE_WORDS];
    // next page of each page in a packet
    page_t             link_mem [NUM_PAGES];

    always_ff @(posedge clk) begin
        if (buf_wr.word_we) begin
            word_mem[{buf_wr.word_page, buf_wr.word_offs}] <= buf_wr.data;
        end
        if (buf_wr.link_we) begin
            link_mem[buf_wr.link_page] <= buf_wr.next_page;
        end
    end

    // one cycle latency, link comes along with every word
    always_ff @(posedge clk) begin
        if (buf_rd.en) begin
            rd_word <= word_mem[{buf_rd.page, buf_rd.offs}];
            rd_link <= link_mem[buf_rd.page];
        end
    end

endmodule

//--- page_free_list.sv
`timescale 1ns/10ps

module page_free_list import switch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  alloc,
    input  logic  release_en,
    input  page_t release_page,
    output page_t alloc_page,
    output logic  full,
    output logic  almost_full
);

    logic [CNT_W-1:0] fresh_cnt;
    logic [CNT_W-1:0] free_cnt;
    page_t            fifo_mem [NUM_PAGES];
    page_t            fifo_rd;
    page_t            fifo_wr;
    logic             fresh_left;

    // untouched pages go out in order, then recycled ones
    assign fresh_left = (fresh_cnt != CNT_W'(NUM_PAGES));
    assign alloc_page = fresh_left ? fresh_cnt[PAGE_W-1:0] : fifo_mem[fifo_rd];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fresh_cnt <= '0;
            free_cnt <= CNT_W'(NUM_PAGES);
            fifo_rd <= '0;
            fifo_wr <= '0;
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            if (alloc && fresh_left) begin
                fresh_cnt <= fresh_cnt + 1'b1;
            end
            if (alloc && !fresh_left) begin
                fifo_rd <= fifo_rd + 1'b1;
            end
            if (release_en) begin
                fifo_wr <= fifo_wr + 1'b1;
            end
            // alloc and release may land together
            free_cnt <= free_cnt + CNT_W'(release_en) - CNT_W'(alloc);
            // flags trail the count by a cycle
            full <= (free_cnt == '0);
            almost_full <= (free_cnt < CNT_W'(MAX_PKT_PAGES));
        end
    end

    // 128 slots, never more pages out than in
    always_ff @(posedge clk) begin
        if (release_en) begin
            fifo_mem[fifo_wr] <= release_page;
        end
    end

endmodule

//--- pkt_switch_top.sv
`timescale 1ns/10ps

module pkt_switch_top import switch_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_sop,
    input  logic                             wr_eop,
    input  logic                             wr_vld,
    input  logic [WORD_W-1:0]                wr_data,
    input  logic [NUM_PORTS-1:0]             ready,
    output logic                             pause,
    output logic                             full,
    output logic                             almost_full,
    output logic [NUM_PORTS-1:0]             rd_sop,
    output logic [NUM_PORTS-1:0]             rd_eop,
    output logic [NUM_PORTS-1:0]             rd_vld,
    output logic [NUM_PORTS-1:0][WORD_W-1:0] rd_data
);

    // ingress side
    logic                  alloc;
    page_t                 alloc_page;
    buf_wr_t               buf_wr;
    logic                  enq;
    pkt_desc_t             enq_desc;

    // egress side
    logic                  deq;
    logic [PORT_W-1:0]     deq_port;
    logic [PRIO_W-1:0]     deq_prio;
    page_t                 head_page;
    logic [NUM_QUEUES-1:0] nonempty;
    buf_rd_t               buf_rd;
    logic [WORD_W-1:0]     rd_word;
    page_t                 rd_link;
    logic                  release_en;
    page_t                 release_page;

    // source holds back once a worst-case packet may not fit
    assign pause = almost_full;

    ingress_ctrl u_ingress_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_sop     (wr_sop),
        .wr_eop     (wr_eop),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .alloc_page (alloc_page),
        .alloc      (alloc),
        .buf_wr     (buf_wr),
        .enq        (enq),
        .enq_desc   (enq_desc)
    );

    page_free_list u_page_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .release_en   (release_en),
        .release_page (release_page),
        .alloc_page   (alloc_page),
        .full         (full),
        .almost_full  (almost_full)
    );

    packet_buffer u_packet_buffer (
        .clk     (clk),
        .buf_wr  (buf_wr),
        .buf_rd  (buf_rd),
        .rd_word (rd_word),
        .rd_link (rd_link)
    );

    queue_table u_queue_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq       (enq),
        .enq_desc  (enq_desc),
        .deq       (deq),
        .deq_port  (deq_port),
        .deq_prio  (deq_prio),
        .head_page (head_page),
        .nonempty  (nonempty)
    );

    egress_sched u_egress_sched (
        .clk          (clk),
        .rst_n        (rst_n),
        .ready        (ready),
        .nonempty     (nonempty),
        .head_page    (head_page),
        .rd_word      (rd_word),
        .rd_link      (rd_link),
        .deq          (deq),
        .deq_port     (deq_port),
        .deq_prio     (deq_prio),
        .buf_rd       (buf_rd),
        .release_en   (release_en),
        .release_page (release_page),
        .rd_sop       (rd_sop),
        .rd_eop       (rd_eop),
        .rd_vld       (rd_vld),
        .rd_data      (rd_data)
    );

endmodule

//--- queue_table.sv
`timescale 1ns/10ps

module queue_table import switch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enq,
    input  pkt_desc_t             enq_desc,
    input  logic                  deq,
    input  logic [PORT_W-1:0]     deq_port,
    input  logic [PRIO_W-1:0]     deq_prio,
    output page_t                 head_page,
    output logic [NUM_QUEUES-1:0] nonempty
);

    // one chain per port and priority, named by head page
    page_t            q_head [NUM_QUEUES];
    page_t            q_tail [NUM_QUEUES];
    logic [CNT_W-1:0] q_cnt [NUM_QUEUES];
    // packet after the one starting at this page
    page_t            next_pkt [NUM_PAGES];

    logic [QID_W-1:0] eq;
    logic [QID_W-1:0] dq;
    logic             head_new;

    assign eq = {enq_desc.dest, enq_desc.prio};
    assign dq = {deq_port, deq_prio};
    assign head_page = q_head[dq];

    // empty queue, or its only packet leaves this cycle
    assign head_new = (q_cnt[eq] == '0)
                   || (deq && (dq == eq) && (q_cnt[eq] == CNT_W'(1)));

    always_comb begin
        for (int i = 0; i < NUM_QUEUES; i++) begin
            nonempty[i] = (q_cnt[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                q_cnt[i] <= '0;
            end
        end else begin
            // same queue on both sides leaves the count unchanged
            for (int i = 0; i < NUM_QUEUES; i++) begin
                q_cnt[i] <= q_cnt[i] + CNT_W'(enq && (eq == QID_W'(i)))
                                     - CNT_W'(deq && (dq == QID_W'(i)));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            q_head[dq] <= next_pkt[q_head[dq]];
        end
        // enqueue after dequeue, so it wins on a shared head
        if (enq) begin
            q_tail[eq] <= enq_desc.head;
            if (head_new) begin
                q_head[eq] <= enq_desc.head;
            end else begin
                next_pkt[q_tail[eq]] <= enq_desc.head;
            end
        end
    end

endmodule

//--- sim.f
switch_pkg.sv
ingress_ctrl.sv
page_free_list.sv
packet_buffer.sv
queue_table.sv
egress_sched.sv
pkt_switch_top.sv
tb_pkt_switch.sv

//--- switch_pkg.sv
package switch_pkg;

    // egress side, priority 3 is served first
    localparam int NUM_PORTS = 4;
    localparam int PORT_W = 2;
    localparam int NUM_PRIO = 4;
    localparam int PRIO_W = 2;
    localparam int NUM_QUEUES = NUM_PORTS * NUM_PRIO;
    localparam int QID_W = PORT_W + PRIO_W;

    // buffer geometry
    localparam int WORD_W = 16;
    localparam int PAGE_WORDS = 8;
    localparam int OFFS_W = 3;
    localparam int NUM_PAGES = 128;
    localparam int PAGE_W = 7;
    // one bit wider than a page number so it can hold 128
    localparam int CNT_W = 8;

    // largest packet, header included
    localparam int MAX_PKT_WORDS = 64;
    localparam int MAX_PKT_PAGES = MAX_PKT_WORDS / PAGE_WORDS;
    localparam int LEN_W = 8;

    // fsm state codes
    localparam logic ING_IDLE = 1'b0;
    localparam logic ING_PKT = 1'b1;
    localparam logic [1:0] EG_IDLE = 2'd0;
    localparam logic [1:0] EG_GRANT = 2'd1;
    localparam logic [1:0] EG_STREAM = 2'd2;

    typedef logic [PAGE_W-1:0] page_t;

    // first word of a packet, length counts the header too
    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [3:0]        rsvd;
        logic [PRIO_W-1:0] prio;
        logic [PORT_W-1:0] dest;
    } pkt_hdr_t;

    // same word seen as payload or as header
    typedef union packed {
        logic [WORD_W-1:0] raw;
        pkt_hdr_t          hdr;
    } pkt_word_u;

    // finished packet handed to the queues
    typedef struct packed {
        logic [PORT_W-1:0] dest;
        logic [PRIO_W-1:0] prio;
        page_t             head;
    } pkt_desc_t;

    typedef struct packed {
        logic              word_we;
        page_t             word_page;
        logic [OFFS_W-1:0] word_offs;
        logic [WORD_W-1:0] data;
        logic              link_we;
        page_t             link_page;
        page_t             next_page;
    } buf_wr_t;

    typedef struct packed {
        logic              en;
        page_t             page;
        logic [OFFS_W-1:0] offs;
    } buf_rd_t;

endpackage

//--- tb_pkt_switch.sv
`timescale 1ns/10ps

module tb_pkt_switch import switch_pkg::*; ();

    logic                             clk;
    logic                             rst_n;
    logic                             wr_sop;
    logic                             wr_eop;
    logic                             wr_vld;
    logic [WORD_W-1:0]                wr_data;
    logic [NUM_PORTS-1:0]             ready;
    logic                             pause;
    logic                             full;
    logic                             almost_full;
    logic [NUM_PORTS-1:0]             rd_sop;
    logic [NUM_PORTS-1:0]             rd_eop;
    logic [NUM_PORTS-1:0]             rd_vld;
    logic [NUM_PORTS-1:0][WORD_W-1:0] rd_data;

    // every word ever sent, packets indexed by id
    logic [WORD_W-1:0] store [$];
    int                pkt_base [$];
    int                pkt_len [$];
    // ids sent but not yet seen on an egress port
    int                pend_q [$];

    // receive side, one packet in flight per port
    logic [NUM_PORTS-1:0] active;
    int                   cur_id [NUM_PORTS];
    int                   cur_idx [NUM_PORTS];

    logic [31:0] lcg_state;
    bit          strict_order;
    bit          timed_out;
    string       test_name;
    int          mismatch_cnt;
    int          fail_cnt;
    int          sent_cnt;
    int          rx_cnt;

    pkt_switch_top u_pkt_switch_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .ready       (ready),
        .pause       (pause),
        .full        (full),
        .almost_full (almost_full),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    initial clk = 1'b0;
    // 100 ns period
    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, low lcg bits are weak
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:8] % n);
    endfunction

    // pages a packet takes, 8 words each
    function automatic int page_cost(input int len);
        return (len + PAGE_WORDS - 1) / PAGE_WORDS;
    endfunction

    // next packet expected on a port
    // strict mode walks priorities from the top, otherwise only the given one
    function automatic int ref_pick(input int port, input int prio, input bit strict_mode);
        pkt_hdr_t hdr;
        int       pos;
        int       id;
        pos = -1;
        id = -1;
        for (int pr = NUM_PRIO - 1; pr >= 0; pr--) begin
            for (int i = 0; i < pend_q.size(); i++) begin
                if (pos < 0 && (strict_mode || pr == prio)) begin
                    hdr = store[pkt_base[pend_q[i]]];
                    if (int'(hdr.dest) == port && int'(hdr.prio) == pr) begin
                        pos = i;
                    end
                end
            end
        end
        if (pos >= 0) begin
            id = pend_q[pos];
            pend_q.delete(pos);
        end
        return id;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // words go out back to back, then two idle cycles so flags settle
    task automatic send_packet(input int dest, input int prio, input int len);
        pkt_hdr_t    hdr;
        logic [31:0] r;
        int          base;
        if (timed_out) return;
        hdr.len = LEN_W'(len);
        hdr.rsvd = '0;
        hdr.prio = PRIO_W'(prio);
        hdr.dest = PORT_W'(dest);
        base = store.size();
        store.push_back(hdr);
        for (int i = 1; i < len; i++) begin
            r = next_rand();
            store.push_back(r[31:16]);
        end
        pkt_base.push_back(base);
        pkt_len.push_back(len);
        pend_q.push_back(pkt_base.size() - 1);
        sent_cnt++;
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            wr_vld <= 1'b1;
            wr_sop <= (i == 0);
            wr_eop <= (i == len - 1);
            wr_data <= store[base + i];
        end
        @(posedge clk);
        wr_vld <= 1'b0;
        wr_sop <= 1'b0;
        wr_eop <= 1'b0;
        wr_data <= '0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic send_random(output int len);
        int dest;
        int prio;
        dest = rand_below(NUM_PORTS);
        prio = rand_below(NUM_PRIO);
        len = 1 + rand_below(MAX_PKT_WORDS);
        send_packet(dest, prio, len);
    endtask

    // called on a falling edge
    task automatic wait_pause_low(input int limit);
        int n;
        n = 0;
        if (timed_out) return;
        while (pause && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pause) begin
            $display("timeout in %s: pause stayed high for %0d cycles", test_name, limit);
            fail_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        if (timed_out) return;
        while ((pend_q.size() != 0 || active != '0) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pend_q.size() != 0 || active != '0) begin
            $display("timeout in %s: %0d packets not delivered after %0d cycles",
                     test_name, pend_q.size(), limit);
            fail_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic set_ready(input logic [NUM_PORTS-1:0] val);
        @(posedge clk);
        ready <= val;
        @(negedge clk);
    endtask

    // load with egress blocked until pause rises
    task automatic fill_buffer();
        int used;
        int loaded;
        int len;
        int free_pages;
        used = 0;
        loaded = 0;
        if (timed_out) return;
        set_ready('0);
        strict_order = 1'b1;
        while (!pause && !timed_out && loaded < 200) begin
            send_random(len);
            used += page_cost(len);
            loaded++;
        end
        repeat (3) @(negedge clk);
        free_pages = NUM_PAGES - used;
        check_value({test_name, " full"}, free_pages == 0, full);
        check_value({test_name, " almost_full"}, free_pages < MAX_PKT_PAGES, almost_full);
        check_value({test_name, " pause"}, free_pages < MAX_PKT_PAGES, pause);
    endtask

    // all pages back once the queues empty
    task automatic drain_all();
        set_ready('1);
        wait_drain(40000);
        strict_order = 1'b0;
        repeat (3) @(negedge clk);
        check_value({test_name, " full after drain"}, 1'b0, full);
        check_value({test_name, " almost_full after drain"}, 1'b0, almost_full);
        check_value({test_name, " pause after drain"}, 1'b0, pause);
    endtask

    task automatic finish_run();
        $display("%0d value mismatches, %0d other failures, %0d of %0d packets received",
                 mismatch_cnt, fail_cnt, rx_cnt, sent_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // egress monitor, outputs settle by the falling edge
    always @(negedge clk) begin : compare_outputs
        pkt_hdr_t    hdr;
        logic [31:0] exp_word;
        logic        exp_eop;
        int          id;
        if (rst_n) begin
            if ($countones(rd_vld) > 1) begin
                $display("%s: more than one egress port sending at once", test_name);
                fail_cnt++;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!rd_vld[p] && (rd_sop[p] || rd_eop[p])) begin
                    $display("%s: port %0d strobe without valid", test_name, p);
                    fail_cnt++;
                end
                if (rd_vld[p] && rd_sop[p]) begin
                    if (active[p]) begin
                        $display("%s: port %0d started a packet inside another", test_name, p);
                        fail_cnt++;
                    end
                    if (!ready[p]) begin
                        $display("%s: port %0d sent a packet while not ready", test_name, p);
                        fail_cnt++;
                    end
                    hdr = rd_data[p];
                    id = ref_pick(p, int'(hdr.prio), strict_order);
                    active[p] = (id >= 0);
                    cur_id[p] = id;
                    cur_idx[p] = 0;
                    if (id < 0) begin
                        $display("%s: port %0d got a packet the model does not expect",
                                 test_name, p);
                        fail_cnt++;
                    end
                end
                if (rd_vld[p] && active[p]) begin
                    exp_word = store[pkt_base[cur_id[p]] + cur_idx[p]];
                    exp_eop = (cur_idx[p] == pkt_len[cur_id[p]] - 1);
                    check_value($sformatf("%s port %0d word %0d", test_name, p, cur_idx[p]),
                                exp_word, rd_data[p]);
                    check_value($sformatf("%s port %0d eop", test_name, p),
                                exp_eop, rd_eop[p]);
                    cur_idx[p]++;
                    if (exp_eop) begin
                        active[p] = 1'b0;
                        rx_cnt++;
                    end
                end else if (rd_vld[p] && !rd_sop[p]) begin
                    $display("%s: port %0d sent a word outside a packet", test_name, p);
                    fail_cnt++;
                end
            end
        end
    end

    initial begin
        int len;
        rst_n <= 1'b0;
        wr_sop <= 1'b0;
        wr_eop <= 1'b0;
        wr_vld <= 1'b0;
        wr_data <= '0;
        ready <= '0;
        lcg_state = 32'h03a6b0fc;
        strict_order = 1'b0;
        timed_out = 1'b0;
        mismatch_cnt = 0;
        fail_cnt = 0;
        sent_cnt = 0;
        rx_cnt = 0;
        active = '0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset pause", 1'b0, pause);
        check_value("reset full", 1'b0, full);
        check_value("reset almost_full", 1'b0, almost_full);
        check_value("reset rd_vld", '0, rd_vld);

        // crosses two page boundaries
        test_name = "single packet";
        set_ready('1);
        send_packet(3, 1, 20);
        wait_drain(2000);

        // port held back so several packets share one chain
        test_name = "fifo order";
        set_ready('0);
        for (int i = 0; i < 5; i++) begin
            send_packet(1, 1, 1 + rand_below(MAX_PKT_WORDS));
        end
        set_ready('1);
        wait_drain(5000);

        // held back, then released highest priority first
        test_name = "strict priority";
        set_ready('0);
        strict_order = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_packet(2, rand_below(NUM_PRIO), 1 + rand_below(24));
        end
        repeat (3) @(negedge clk);
        set_ready(4'b0100);
        wait_drain(5000);
        strict_order = 1'b0;

        test_name = "routing";
        set_ready('1);
        for (int i = 0; i < 40; i++) begin
            wait_pause_low(5000);
            send_random(len);
        end
        wait_drain(20000);

        test_name = "buffer flags";
        fill_buffer();
        drain_all();

        // second fill runs on recycled pages
        test_name = "page recycling";
        fill_buffer();
        drain_all();

        finish_run();
    end

endmodule
